// ==== Makefile ====
TOP = gb_memory_map_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

// ==== sim.f ====
+incdir+source
source/gb_memory_map_pkg.sv
source/region_if.sv
source/address_decoder.sv
source/work_ram.sv
source/system_registers.sv
source/read_data_mux.sv
source/gb_memory_map.sv
tb/gb_memory_map_props.sv
tb/gb_memory_map_tb.sv

// ==== source/address_decoder.sv ====
////////////////////////////////////////
// Address decoder
// Maps a CPU address onto a region and folds work RAM and echo
// addresses into one RAM index
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

module address_decoder (
   region_if.decoder          bus,
   input  logic [`ADDR_W-1:0] addr,
   input  logic [`DATA_W-1:0] wdata,
   input  logic               we,
   input  logic               re,
   input  logic               boot_unmapped,
   output logic               video_we,
   output logic               joypad_we
);
   import gb_memory_map_pkg::*;

   region_e            region_sel;
   logic [`ADDR_W-1:0] wram_offset;

   // Ranges are tested in ascending address order
   always_comb begin
      region_sel  = region_unmapped;
      wram_offset = '0;
      if (addr <= `BOOT_END) begin
         region_sel = boot_unmapped ? region_cart : region_boot;
      end else if (addr <= `CART_END) begin
         region_sel = region_cart;
      end else if (addr >= `VRAM_START && addr <= `VRAM_END) begin
         region_sel = region_video;
      end else if (addr >= `WRAM_START && addr <= `WRAM_END) begin
         region_sel  = region_wram;
         wram_offset = addr - `WRAM_START;
      end else if (addr >= `ECHO_START && addr <= `ECHO_END) begin
         // Echo reuses the same RAM bytes
         region_sel  = region_wram;
         wram_offset = addr - `ECHO_START;
      end else if (addr >= `OAM_START && addr <= `OAM_END) begin
         region_sel = region_video;
      end else if (addr == `MMIO_JOYPAD) begin
         region_sel = region_joypad;
      end else if (addr == `MMIO_IF) begin
         region_sel = region_if;
      end else if (addr >= `VREG_START && addr <= `VREG_END) begin
         region_sel = region_video;
      end else if (addr == `MMIO_BOOTSTRAP) begin
         region_sel = region_bootstrap;
      end else if (addr == `MMIO_IE) begin
         region_sel = region_ie;
      end
   end

   assign bus.region     = region_sel;
   assign bus.wram_index = wram_offset[`WRAM_IDX_W-1:0];
   assign bus.wdata      = wdata;
   assign bus.we         = we;
   assign bus.re         = re;

   // Write strobes for the blocks kept outside
   assign video_we  = we && (region_sel == region_video);
   assign joypad_we = we && (region_sel == region_joypad);

endmodule

// ==== source/gb_memory_map.sv ====
////////////////////////////////////////
// Memory map fabric
// CPU bus decode, work RAM, system registers and read return
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

module gb_memory_map (
   input  logic               clock,
   input  logic               reset,
   input  logic [`ADDR_W-1:0] addr,
   input  logic [`DATA_W-1:0] wdata,
   input  logic               we,
   input  logic               re,
   input  logic [`DATA_W-1:0] boot_rdata,
   input  logic [`DATA_W-1:0] cart_rdata,
   input  logic [`DATA_W-1:0] video_rdata,
   input  logic [`DATA_W-1:0] joypad_rdata,
   input  logic               irq_vblank,
   input  logic               irq_lcdc,
   input  logic               irq_timer,
   input  logic               irq_joypad,
   output logic [`DATA_W-1:0] rdata,
   output logic               rdata_valid,
   output logic               video_we,
   output logic               joypad_we,
   output logic               int_pending
);

   logic               boot_unmapped;
   logic [`DATA_W-1:0] ram_rdata;
   logic [`DATA_W-1:0] reg_rdata;

   region_if bus ();

   address_decoder u_decoder (
      .bus           (bus.decoder),
      .addr          (addr),
      .wdata         (wdata),
      .we            (we),
      .re            (re),
      .boot_unmapped (boot_unmapped),
      .video_we      (video_we),
      .joypad_we     (joypad_we)
   );

   work_ram u_work_ram (
      .clock (clock),
      .bus   (bus.target),
      .rdata (ram_rdata)
   );

   system_registers u_system_registers (
      .clock         (clock),
      .reset         (reset),
      .bus           (bus.target),
      .irq_vblank    (irq_vblank),
      .irq_lcdc      (irq_lcdc),
      .irq_timer     (irq_timer),
      .irq_joypad    (irq_joypad),
      .boot_unmapped (boot_unmapped),
      .int_pending   (int_pending),
      .rdata         (reg_rdata)
   );

   // Both targets answer one cycle after the read
   read_data_mux u_read_data_mux (
      .clock        (clock),
      .reset        (reset),
      .bus          (bus.target),
      .ram_rdata    (ram_rdata),
      .reg_rdata    (reg_rdata),
      .boot_rdata   (boot_rdata),
      .cart_rdata   (cart_rdata),
      .video_rdata  (video_rdata),
      .joypad_rdata (joypad_rdata),
      .rdata        (rdata),
      .rdata_valid  (rdata_valid)
   );

endmodule

// ==== source/gb_memory_map_defines.svh ====
////////////////////////////////////////
// Memory map constants
// Bus widths and the address boundaries of each region in the
// console's 16-bit CPU address space
////////////////////////////////////////

`ifndef GB_MEMORY_MAP_DEFINES_SVH
`define GB_MEMORY_MAP_DEFINES_SVH

// Bus widths
`define ADDR_W 16
`define DATA_W 8
`define WRAM_IDX_W 13
`define IRQ_W 5

// Boot ROM overlays the bottom of cartridge space
`define BOOT_END 16'h00FF
`define CART_END 16'h7FFF

`define VRAM_START 16'h8000
`define VRAM_END 16'h9FFF

// Echo window mirrors work RAM
`define WRAM_START 16'hC000
`define WRAM_END 16'hDFFF
`define ECHO_START 16'hE000
`define ECHO_END 16'hFDFF

`define OAM_START 16'hFE00
`define OAM_END 16'hFE9F
`define VREG_START 16'hFF40
`define VREG_END 16'hFF4B

// Single-register MMIO locations
`define MMIO_JOYPAD 16'hFF00
`define MMIO_IF 16'hFF0F
`define MMIO_BOOTSTRAP 16'hFF50
`define MMIO_IE 16'hFFFF

`endif

// ==== source/gb_memory_map_pkg.sv ====
////////////////////////////////////////
// Memory map types
// Region selection and interrupt bit positions
////////////////////////////////////////

package gb_memory_map_pkg;

   // Target selected by the address decoder
   typedef enum logic [3:0] {
      region_boot,
      region_cart,
      region_video,
      region_wram,
      region_joypad,
      region_if,
      region_ie,
      region_bootstrap,
      // Anything not listed above, sound range included
      region_unmapped
   } region_e;

   // Bit positions within IF and IE
   typedef enum logic [2:0] {
      irq_vblank = 3'd0,
      irq_lcdc   = 3'd1,
      irq_timer  = 3'd2,
      // Serial link is not implemented, only software sets this bit
      irq_serial = 3'd3,
      irq_joypad = 3'd4
   } irq_bit_e;

endpackage

// ==== source/read_data_mux.sv ====
////////////////////////////////////////
// Read data return path
// Steers one byte back from the region read in the previous cycle
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

module read_data_mux (
   input  logic               clock,
   input  logic               reset,
   region_if.target           bus,
   input  logic [`DATA_W-1:0] ram_rdata,
   input  logic [`DATA_W-1:0] reg_rdata,
   input  logic [`DATA_W-1:0] boot_rdata,
   input  logic [`DATA_W-1:0] cart_rdata,
   input  logic [`DATA_W-1:0] video_rdata,
   input  logic [`DATA_W-1:0] joypad_rdata,
   output logic [`DATA_W-1:0] rdata,
   output logic               rdata_valid
);
   import gb_memory_map_pkg::*;

   region_e            region_q;
   logic [`DATA_W-1:0] boot_q;
   logic [`DATA_W-1:0] cart_q;
   logic [`DATA_W-1:0] video_q;
   logic [`DATA_W-1:0] joypad_q;

   // Unmapped after reset so rdata starts at zero
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         region_q    <= region_unmapped;
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= bus.re;
         if (bus.re) begin
            region_q <= bus.region;
         end
      end
   end

   // External bytes captured in the read cycle itself
   always_ff @(posedge clock) begin
      if (bus.re) begin
         boot_q   <= boot_rdata;
         cart_q   <= cart_rdata;
         video_q  <= video_rdata;
         joypad_q <= joypad_rdata;
      end
   end

   always_comb begin
      case (region_q)
         region_wram:      rdata = ram_rdata;
         region_if,
         region_ie,
         region_bootstrap: rdata = reg_rdata;
         region_boot:      rdata = boot_q;
         region_cart:      rdata = cart_q;
         region_video:     rdata = video_q;
         region_joypad:    rdata = joypad_q;
         default:          rdata = '0;
      endcase
   end

endmodule

// ==== source/region_if.sv ====
////////////////////////////////////////
// Decoded access bundle
// Carries one bus access from the decoder to the memory targets
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

interface region_if;
   import gb_memory_map_pkg::*;

   region_e                 region;
   // Folded offset into work RAM, valid in region_wram only
   logic [`WRAM_IDX_W-1:0]  wram_index;
   logic [`DATA_W-1:0]      wdata;
   logic                    we;
   logic                    re;

   modport decoder (
      output region,
      output wram_index,
      output wdata,
      output we,
      output re
   );

   modport target (
      input region,
      input wram_index,
      input wdata,
      input we,
      input re
   );

endinterface

// ==== source/system_registers.sv ====
////////////////////////////////////////
// System registers
// Bootstrap latch plus interrupt flag and enable registers
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

module system_registers (
   input  logic               clock,
   input  logic               reset,
   region_if.target           bus,
   input  logic               irq_vblank,
   input  logic               irq_lcdc,
   input  logic               irq_timer,
   input  logic               irq_joypad,
   output logic               boot_unmapped,
   output logic               int_pending,
   output logic [`DATA_W-1:0] rdata
);
   import gb_memory_map_pkg::*;

   logic [`DATA_W-1:0] bootstrap_q;
   logic [`IRQ_W-1:0]  if_q;
   logic [`IRQ_W-1:0]  ie_q;
   logic [`IRQ_W-1:0]  irq_set;
   logic [`IRQ_W-1:0]  if_next;

   // Hardware request lines, serial has no source
   always_comb begin
      irq_set                                = '0;
      irq_set[gb_memory_map_pkg::irq_vblank] = irq_vblank;
      irq_set[gb_memory_map_pkg::irq_lcdc]   = irq_lcdc;
      irq_set[gb_memory_map_pkg::irq_timer]  = irq_timer;
      irq_set[gb_memory_map_pkg::irq_joypad] = irq_joypad;
   end

   // CPU write replaces IF, a request in the same cycle still lands
   always_comb begin
      if (bus.we && bus.region == region_if) begin
         if_next = bus.wdata[`IRQ_W-1:0];
      end else begin
         if_next = if_q;
      end
      if_next = if_next | irq_set;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         bootstrap_q <= '0;
         if_q        <= '0;
         ie_q        <= '0;
      end else begin
         if_q <= if_next;
         if (bus.we && bus.region == region_bootstrap) begin
            bootstrap_q <= bus.wdata;
         end
         if (bus.we && bus.region == region_ie) begin
            ie_q <= bus.wdata[`IRQ_W-1:0];
         end
      end
   end

   always_ff @(posedge clock) begin
      if (bus.re) begin
         case (bus.region)
            region_if:        rdata <= {{(`DATA_W-`IRQ_W){1'b0}}, if_q};
            region_ie:        rdata <= {{(`DATA_W-`IRQ_W){1'b0}}, ie_q};
            region_bootstrap: rdata <= bootstrap_q;
            default:          rdata <= '0;
         endcase
      end
   end

   assign boot_unmapped = bootstrap_q[0];
   assign int_pending   = |(if_q & ie_q);

endmodule

// ==== source/work_ram.sv ====
////////////////////////////////////////
// Work RAM
// 8 KiB synchronous byte RAM behind the work and echo windows
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

module work_ram (
   input  logic               clock,
   region_if.target           bus,
   output logic [`DATA_W-1:0] rdata
);
   import gb_memory_map_pkg::*;

   localparam int DEPTH = 1 << `WRAM_IDX_W;

   logic [`DATA_W-1:0] mem [0:DEPTH-1];
   logic               hit;

   assign hit = (bus.region == region_wram);

   always_ff @(posedge clock) begin
      if (bus.we && hit) begin
         mem[bus.wram_index] <= bus.wdata;
      end
   end

   // Read port only moves on a work RAM read, so the byte holds until
   // the next one
   always_ff @(posedge clock) begin
      if (bus.re && hit) begin
         rdata <= mem[bus.wram_index];
      end
   end

endmodule

// ==== tb/gb_memory_map_props.sv ====
////////////////////////////////////////
// Memory map checker
// Shadow copy of RAM and registers built from the bus, with
// concurrent assertions on the read path and the strobes
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

module gb_memory_map_props (
   input logic               clock,
   input logic               reset,
   input logic [`ADDR_W-1:0] addr,
   input logic [`DATA_W-1:0] wdata,
   input logic               we,
   input logic               re,
   input logic [`DATA_W-1:0] boot_rdata,
   input logic [`DATA_W-1:0] cart_rdata,
   input logic [`DATA_W-1:0] video_rdata,
   input logic [`DATA_W-1:0] joypad_rdata,
   input logic               irq_vblank,
   input logic               irq_lcdc,
   input logic               irq_timer,
   input logic               irq_joypad,
   input logic [`DATA_W-1:0] rdata,
   input logic               rdata_valid,
   input logic               video_we,
   input logic               joypad_we,
   input logic               int_pending
);

   localparam int DEPTH = 1 << `WRAM_IDX_W;

   logic [`DATA_W-1:0]    mem_s [0:DEPTH-1];
   logic [DEPTH-1:0]      known_s;
   logic [`DATA_W-1:0]    boot_s;
   logic [`IRQ_W-1:0]     if_s;
   logic [`IRQ_W-1:0]     ie_s;
   logic [`IRQ_W-1:0]     hw_irq;
   logic [`DATA_W-1:0]    exp_next;
   logic                  exp_known;
   logic [`DATA_W-1:0]    exp_q;
   logic                  exp_known_q;
   logic                  re_q;
   logic [`WRAM_IDX_W-1:0] idx;

   // Assertion failures so far
   int error_count = 0;

   function automatic logic in_video(input logic [`ADDR_W-1:0] a);
      return (a >= `VRAM_START && a <= `VRAM_END) ||
             (a >= `OAM_START && a <= `OAM_END) ||
             (a >= `VREG_START && a <= `VREG_END);
   endfunction

   function automatic logic in_wram(input logic [`ADDR_W-1:0] a);
      return a >= `WRAM_START && a <= `ECHO_END;
   endfunction

   // Work and echo windows fold onto the same byte
   function automatic logic [`WRAM_IDX_W-1:0] wram_idx(input logic [`ADDR_W-1:0] a);
      logic [`ADDR_W-1:0] off;
      off = (a >= `ECHO_START) ? a - `ECHO_START : a - `WRAM_START;
      return off[`WRAM_IDX_W-1:0];
   endfunction

   assign idx = wram_idx(addr);

   // Serial bit has no hardware source
   assign hw_irq = {irq_joypad, 1'b0, irq_timer, irq_lcdc, irq_vblank};

   always_comb begin
      exp_known = 1'b1;
      if (addr <= `BOOT_END) begin
         exp_next = boot_s[0] ? cart_rdata : boot_rdata;
      end else if (addr <= `CART_END) begin
         exp_next = cart_rdata;
      end else if (in_video(addr)) begin
         exp_next = video_rdata;
      end else if (in_wram(addr)) begin
         exp_next  = mem_s[idx];
         exp_known = known_s[idx];
      end else if (addr == `MMIO_JOYPAD) begin
         exp_next = joypad_rdata;
      end else if (addr == `MMIO_IF) begin
         exp_next = {3'b000, if_s};
      end else if (addr == `MMIO_IE) begin
         exp_next = {3'b000, ie_s};
      end else if (addr == `MMIO_BOOTSTRAP) begin
         exp_next = boot_s;
      end else begin
         exp_next = 8'h00;
      end
   end

   always_ff @(posedge clock) begin
      if (we && in_wram(addr)) begin
         mem_s[idx] <= wdata;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         known_s     <= '0;
         boot_s      <= '0;
         if_s        <= '0;
         ie_s        <= '0;
         exp_q       <= '0;
         exp_known_q <= 1'b0;
         re_q        <= 1'b0;
      end else begin
         re_q <= re;
         if (re) begin
            exp_q       <= exp_next;
            exp_known_q <= exp_known;
         end
         if (we && in_wram(addr)) begin
            known_s[idx] <= 1'b1;
         end
         if (we && addr == `MMIO_BOOTSTRAP) begin
            boot_s <= wdata;
         end
         if (we && addr == `MMIO_IE) begin
            ie_s <= wdata[`IRQ_W-1:0];
         end
         if_s <= ((we && addr == `MMIO_IF) ? wdata[`IRQ_W-1:0] : if_s) | hw_irq;
      end
   end

   a_valid_in_reset: assert property (@(posedge clock) reset |-> !rdata_valid)
   else begin
      error_count++;
      $error("rdata_valid was high while reset was asserted");
   end

   a_valid_follows_re: assert property (@(posedge clock) disable iff (reset)
      rdata_valid == re_q)
   else begin
      error_count++;
      $error("FAIL rdata_valid got %h expected %h", $sampled(rdata_valid), $sampled(re_q));
   end

   a_read_data: assert property (@(posedge clock) disable iff (reset)
      (rdata_valid && exp_known_q) |-> rdata == exp_q)
   else begin
      error_count++;
      $error("FAIL rdata got %h expected %h", $sampled(rdata), $sampled(exp_q));
   end

   a_int_pending: assert property (@(posedge clock) disable iff (reset)
      int_pending == |(if_s & ie_s))
   else begin
      error_count++;
      $error("FAIL int_pending got %h expected %h", $sampled(int_pending),
             $sampled(|(if_s & ie_s)));
   end

   a_video_we: assert property (@(posedge clock) disable iff (reset)
      video_we == (we && in_video(addr)))
   else begin
      error_count++;
      $error("FAIL video_we got %h at addr %h", $sampled(video_we), $sampled(addr));
   end

   a_joypad_we: assert property (@(posedge clock) disable iff (reset)
      joypad_we == (we && addr == `MMIO_JOYPAD))
   else begin
      error_count++;
      $error("FAIL joypad_we got %h at addr %h", $sampled(joypad_we), $sampled(addr));
   end

endmodule

bind gb_memory_map gb_memory_map_props props (.*);

// ==== tb/gb_memory_map_tb.sv ====
////////////////////////////////////////
// Memory map testbench
// Random bus traffic through every region, checked by the bound
// assertion module
////////////////////////////////////////

`timescale 1ns/1ps
`include "gb_memory_map_defines.svh"

module gb_memory_map_tb;

   logic               clock;
   logic               reset;
   logic [`ADDR_W-1:0] addr;
   logic [`DATA_W-1:0] wdata;
   logic               we;
   logic               re;
   logic [`DATA_W-1:0] boot_rdata;
   logic [`DATA_W-1:0] cart_rdata;
   logic [`DATA_W-1:0] video_rdata;
   logic [`DATA_W-1:0] joypad_rdata;
   logic               irq_vblank;
   logic               irq_lcdc;
   logic               irq_timer;
   logic               irq_joypad;
   logic [`DATA_W-1:0] rdata;
   logic               rdata_valid;
   logic               video_we;
   logic               joypad_we;
   logic               int_pending;

   int seed = 32'h4816cf35;
   int timeouts = 0;
   int phases = 0;
   int last_errors = 0;
   logic [`WRAM_IDX_W-1:0] written [$];

   // Video, joypad and a few holes in the map
   localparam logic [`ADDR_W-1:0] PROBES [12] = '{
      16'h8123, 16'h9FFF, 16'hFE00, 16'hFE9F, 16'hFF40, 16'hFF4B,
      `MMIO_JOYPAD, 16'hA000, 16'hFEA0, 16'hFF10, 16'hFF4C, 16'hFF80
   };

   gb_memory_map dut (.*);

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   function automatic logic [`ADDR_W-1:0] wram_addr(input logic [`WRAM_IDX_W-1:0] idx,
                                                   input logic echo);
      // Echo stops 512 bytes short of the RAM's top
      if (echo && `ADDR_W'(idx) <= `ECHO_END - `ECHO_START) begin
         return `ECHO_START + `ADDR_W'(idx);
      end
      return `WRAM_START + `ADDR_W'(idx);
   endfunction

   // Fresh external bytes on every access
   task automatic drive_access(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d,
                               input logic w, input logic r);
      addr         = a;
      wdata        = d;
      we           = w;
      re           = r;
      boot_rdata   = 8'($random(seed));
      cart_rdata   = 8'($random(seed));
      video_rdata  = 8'($random(seed));
      joypad_rdata = 8'($random(seed));
      @(negedge clock);
      we = 1'b0;
      re = 1'b0;
   endtask

   task automatic write_byte(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d);
      drive_access(a, d, 1'b1, 1'b0);
   endtask

   task automatic read_and_wait(input logic [`ADDR_W-1:0] a);
      int waited;
      drive_access(a, 8'h00, 1'b0, 1'b1);
      waited = 0;
      while (!rdata_valid && waited < 4) begin
         @(negedge clock);
         waited++;
      end
      if (!rdata_valid) begin
         timeouts++;
         $display("Read at address %h never raised rdata_valid", a);
      end
      @(negedge clock);
   endtask

   task automatic pulse_irq(input logic [3:0] lines);
      {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = lines;
      @(negedge clock);
      {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = 4'b0000;
   endtask

   // IF write racing hardware requests in the same cycle
   task automatic clash_if_write(input logic [`DATA_W-1:0] d, input logic [3:0] lines);
      {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = lines;
      write_byte(`MMIO_IF, d);
      {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = 4'b0000;
   endtask

   task automatic finish_phase(input string name);
      int total;
      total = dut.props.error_count;
      phases++;
      $display("%s done: %0d assertion failures", name, total - last_errors);
      last_errors = total;
   endtask

   initial begin
      logic [`WRAM_IDX_W-1:0] idx;
      int errors;
      reset = 1'b1;
      addr = '0;
      wdata = '0;
      we = 1'b0;
      // Read held high through reset, no valid may come back
      re = 1'b1;
      boot_rdata = '0;
      cart_rdata = '0;
      video_rdata = '0;
      joypad_rdata = '0;
      {irq_joypad, irq_timer, irq_lcdc, irq_vblank} = 4'b0000;
      repeat (8) @(posedge clock);
      @(negedge clock);
      reset = 1'b0;
      re = 1'b0;

      repeat (24) begin
         idx = `WRAM_IDX_W'($random(seed));
         written.push_back(idx);
         write_byte(wram_addr(idx, 1'($random(seed))), 8'($random(seed)));
      end
      foreach (written[i]) begin
         read_and_wait(wram_addr(written[i], 1'($random(seed))));
      end
      finish_phase("work ram and echo");

      repeat (4) read_and_wait({8'h00, 8'($random(seed))});
      write_byte(`MMIO_BOOTSTRAP, 8'h01);
      read_and_wait(`MMIO_BOOTSTRAP);
      repeat (4) read_and_wait({8'h00, 8'($random(seed))});
      repeat (4) read_and_wait({1'b0, 15'($random(seed))});
      finish_phase("boot rom overlay");

      write_byte(`MMIO_IE, 8'($random(seed)));
      read_and_wait(`MMIO_IE);
      repeat (12) begin
         pulse_irq(4'($random(seed)));
         read_and_wait(`MMIO_IF);
      end
      write_byte(`MMIO_IF, 8'hFF);
      read_and_wait(`MMIO_IF);
      clash_if_write(8'h00, 4'($random(seed)) | 4'b0001);
      read_and_wait(`MMIO_IF);
      write_byte(`MMIO_IE, 8'hFF);
      read_and_wait(`MMIO_IE);
      finish_phase("interrupt registers");

      foreach (PROBES[i]) begin
         write_byte(PROBES[i], 8'($random(seed)));
         read_and_wait(PROBES[i]);
      end
      repeat (16) begin
         idx = `WRAM_IDX_W'($random(seed));
         write_byte({3'b100, idx}, 8'($random(seed)));
         read_and_wait({3'b100, idx});
      end
      finish_phase("video and unmapped");

      errors = dut.props.error_count;
      $display("Summary: %0d phases, %0d assertion failures, %0d timeouts",
               phases, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
